// ==== rtl/noc_pkg.sv ====
// Mesh link definitions
`default_nettype none

package noc_pkg;

  localparam int num_dirs_lp      = 5;   // P, W, E, N, S
  localparam int dir_width_lp     = 3;   // Enough for five directions
  localparam int x_cord_width_lp  = 3;
  localparam int y_cord_width_lp  = 3;
  localparam int payload_width_lp = 16;

  // Port directions, also used as row and column index of request matrices
  typedef enum logic [dir_width_lp-1:0] {
    P = 3'd0,  // Local processor
    W = 3'd1,
    E = 3'd2,
    N = 3'd3,
    S = 3'd4
  } dir_e;

  typedef logic [x_cord_width_lp-1:0] x_cord_t;
  typedef logic [y_cord_width_lp-1:0] y_cord_t;

  // One bit per port direction
  typedef logic [num_dirs_lp-1:0] dir_vec_t;

  // Destination x sits in the low bits of the flit
  typedef struct packed {
    logic [payload_width_lp-1:0] payload;  // Upper 16 bits
    y_cord_t                     y_cord;   // Destination row
    x_cord_t                     x_cord;   // Destination column
  } flit_s;

endpackage

`default_nettype wire

// ==== rtl/mesh_router_pkg.sv ====
// Mesh router definitions
`default_nettype none

package mesh_router_pkg;

  localparam int fifo_depth_lp     = 4;                          // Flits per input FIFO
  localparam int fifo_ptr_width_lp = $clog2(fifo_depth_lp);      // Read/write pointer
  localparam int fifo_cnt_width_lp = $clog2(fifo_depth_lp + 1);  // Occupancy 0..depth

  // Five direction rows, one bit per direction in each
  typedef noc_pkg::dir_vec_t [noc_pkg::num_dirs_lp-1:0] req_matrix_t;

  // Legal turns for x-first routing, row is the output, bit is the input
  localparam req_matrix_t routing_matrix_lp = {
    5'b01111,  // S out takes all but S
    5'b10111,  // N out takes all but N
    5'b00011,  // E out takes P and W
    5'b00101,  // W out takes P and E
    5'b11111   // P out takes everything
  };

endpackage

`default_nettype wire

// ==== rtl/input_fifo.sv ====
// Router input FIFO
`timescale 1ns/1ps
`default_nettype none

module input_fifo (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           v_i,
  input  noc_pkg::flit_s data_i,
  output logic           ready_o,
  output logic           v_o,
  output noc_pkg::flit_s data_o,
  input  logic           yumi_i
);

  import noc_pkg::*;
  import mesh_router_pkg::*;

  flit_s                        mem_r [fifo_depth_lp];  // Flit storage
  logic [fifo_ptr_width_lp-1:0] wr_ptr_r;
  logic [fifo_ptr_width_lp-1:0] rd_ptr_r;
  logic [fifo_cnt_width_lp-1:0] count_r;
  logic                         full;
  logic                         push;
  logic                         pop;

  assign full    = (count_r == fifo_cnt_width_lp'(fifo_depth_lp));
  assign ready_o = ~full | yumi_i;    // A pop frees the slot in the same cycle
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rd_ptr_r];
  assign push    = v_i & ready_o;
  assign pop     = yumi_i;

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= (wr_ptr_r == fifo_ptr_width_lp'(fifo_depth_lp - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == fifo_ptr_width_lp'(fifo_depth_lp - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      if (push && !pop) count_r <= count_r + 1'b1;
      else if (pop && !push) count_r <= count_r - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_r[wr_ptr_r] <= data_i;
  end

  // Occupancy never runs past the depth
  no_overflow_a: assert property (@(posedge clk_i) disable iff (!reset_i)
    count_r <= fifo_cnt_width_lp'(fifo_depth_lp));

  // The crossbar only takes a flit that is really at the head
  no_underflow_a: assert property (@(posedge clk_i) disable iff (!reset_i)
    yumi_i |-> v_o);

endmodule

`default_nettype wire

// ==== rtl/dor_decoder.sv ====
// X-first route decoder
`timescale 1ns/1ps
`default_nettype none

module dor_decoder (
  input  noc_pkg::flit_s    data_i,
  input  noc_pkg::x_cord_t  my_x_i,
  input  noc_pkg::y_cord_t  my_y_i,
  output noc_pkg::dir_vec_t req_o
);

  import noc_pkg::*;

  logic x_lt;  // Destination lies west
  logic x_gt;  // Destination lies east
  logic y_lt;  // Destination lies north
  logic y_gt;  // Destination lies south

  assign x_lt = (data_i.x_cord < my_x_i);
  assign x_gt = (data_i.x_cord > my_x_i);
  assign y_lt = (data_i.y_cord < my_y_i);
  assign y_gt = (data_i.y_cord > my_y_i);

  // Finish x before touching y, exactly one bit set
  always_comb begin
    req_o = '0;
    if (x_lt) begin
      req_o[W] = 1'b1;
    end else if (x_gt) begin
      req_o[E] = 1'b1;
    end else if (y_lt) begin
      req_o[N] = 1'b1;
    end else if (y_gt) begin
      req_o[S] = 1'b1;
    end else begin
      req_o[P] = 1'b1;  // Arrived at this node
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rr_arbiter.sv ====
// Round-robin output arbiter
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter (
  input  logic              clk_i,
  input  logic              reset_i,
  input  noc_pkg::dir_vec_t reqs_i,
  output noc_pkg::dir_vec_t grants_o,
  input  logic              yumi_i
);

  import noc_pkg::*;

  dir_e ptr_r;      // Highest priority input
  dir_e ptr_n;
  dir_e grant_idx;  // Input picked this cycle

  // Scan from the pointer, wrapping past S back to P
  always_comb begin
    int unsigned idx;
    grants_o  = '0;
    grant_idx = ptr_r;
    for (int k = num_dirs_lp - 1; k >= 0; k--) begin
      idx = (int'(ptr_r) + k) % num_dirs_lp;
      if (reqs_i[idx]) begin
        grants_o  = '0;
        grants_o[idx] = 1'b1;  // Lower offsets overwrite, nearest wins
        grant_idx = dir_e'(idx);
      end
    end
  end

  assign ptr_n = (int'(grant_idx) == num_dirs_lp - 1) ? P : dir_e'(int'(grant_idx) + 1);

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      ptr_r <= P;
    end else if (yumi_i) begin
      ptr_r <= ptr_n;  // Move only on a completed transfer
    end
  end

  grant_onehot_a: assert property (@(posedge clk_i) disable iff (!reset_i)
    $onehot0(grants_o) && ((grants_o & ~reqs_i) == '0));

endmodule

`default_nettype wire

// ==== rtl/output_crossbar.sv ====
// Router output crossbar
`timescale 1ns/1ps
`default_nettype none

module output_crossbar (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  input  mesh_router_pkg::req_matrix_t                   req_i,
  input  noc_pkg::flit_s [noc_pkg::num_dirs_lp-1:0]      data_i,
  input  noc_pkg::dir_vec_t                              ready_i,
  output noc_pkg::dir_vec_t                              v_o,
  output noc_pkg::flit_s [noc_pkg::num_dirs_lp-1:0]      data_o,
  output noc_pkg::dir_vec_t                              yumi_o
);

  import noc_pkg::*;
  import mesh_router_pkg::*;

  req_matrix_t req_t;    // Row per output
  req_matrix_t grants;   // Row per output
  req_matrix_t yumi_lo;  // Row per output
  req_matrix_t yumi_t;   // Row per input

  for (genvar o = 0; o < num_dirs_lp; o++) begin : g_out
    for (genvar i = 0; i < num_dirs_lp; i++) begin : g_tp
      assign req_t[o][i]  = req_i[i][o];
      assign yumi_t[i][o] = yumi_lo[o][i];
    end

    assign v_o[o] = |req_t[o];

    rr_arbiter arb (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .reqs_i   (req_t[o]),
      .grants_o (grants[o]),
      .yumi_i   (v_o[o] & ready_i[o])
    );

    assign yumi_lo[o] = grants[o] & {num_dirs_lp{ready_i[o]}};

    // Decoders must never ask for a turn x-first routing forbids
    route_legal_a: assert property (@(posedge clk_i) disable iff (!reset_i)
      (req_t[o] & ~routing_matrix_lp[o]) == '0);
  end

  // One-hot select of the granted head flit
  always_comb begin
    data_o = '0;
    for (int o = 0; o < num_dirs_lp; o++) begin
      for (int i = 0; i < num_dirs_lp; i++) begin
        if (grants[o][i]) data_o[o] = data_i[i];
      end
    end
  end

  for (genvar i = 0; i < num_dirs_lp; i++) begin : g_in
    assign yumi_o[i] = |yumi_t[i];

    // Two outputs can not take the same head flit
    single_yumi_a: assert property (@(posedge clk_i) disable iff (!reset_i)
      $onehot0(yumi_t[i]));
  end

endmodule

`default_nettype wire

// ==== rtl/mesh_router.sv ====
// 2-D mesh router node
`timescale 1ns/1ps
`default_nettype none

module mesh_router (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  noc_pkg::dir_vec_t                         link_v_i,
  input  noc_pkg::flit_s [noc_pkg::num_dirs_lp-1:0] link_data_i,
  output noc_pkg::dir_vec_t                         link_ready_o,
  output noc_pkg::dir_vec_t                         out_v_o,
  output noc_pkg::flit_s [noc_pkg::num_dirs_lp-1:0] out_data_o,
  input  noc_pkg::dir_vec_t                         out_ready_i,
  input  noc_pkg::x_cord_t                          my_x_i,
  input  noc_pkg::y_cord_t                          my_y_i
);

  import noc_pkg::*;
  import mesh_router_pkg::*;

  dir_vec_t                     head_v;     // FIFO not empty
  flit_s [num_dirs_lp-1:0]      head_data;
  dir_vec_t                     yumi;       // Head consumed by the crossbar
  req_matrix_t                  dec_req;    // Raw decoder output
  req_matrix_t                  req;        // Gated by head valid

  for (genvar i = 0; i < num_dirs_lp; i++) begin : g_port
    input_fifo fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .v_i     (link_v_i[i]),
      .data_i  (link_data_i[i]),
      .ready_o (link_ready_o[i]),
      .v_o     (head_v[i]),
      .data_o  (head_data[i]),
      .yumi_i  (yumi[i])
    );

    dor_decoder dec (
      .data_i (head_data[i]),
      .my_x_i (my_x_i),
      .my_y_i (my_y_i),
      .req_o  (dec_req[i])
    );

    assign req[i] = dec_req[i] & {num_dirs_lp{head_v[i]}};
  end

  output_crossbar xbar (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (req),
    .data_i  (head_data),
    .ready_i (out_ready_i),
    .v_o     (out_v_o),
    .data_o  (out_data_o),
    .yumi_o  (yumi)
  );

endmodule

`default_nettype wire

// ==== tests/mesh_router_vectors.svh ====
// Router stimulus table
// Columns: name, group, input port, flit {payload, dest y, dest x}, expected output
// Groups: 0 contention on N, 1 single flits, 2 order on one input,
// 3 back-pressure fill, 4 random ready

typedef struct packed {
  logic [63:0] name;     // Eight characters
  logic [2:0]  grp;
  dir_e        in_port;
  flit_s       flit;
  dir_e        exp_dir;
} vec_s;

localparam int num_vecs_lp = 28;

localparam vec_s vec_tbl [num_vecs_lp] = '{
  '{"cont_w_1", 3'd0, W, '{16'h1001, 3'd1, 3'd3}, N},
  '{"cont_e_1", 3'd0, E, '{16'h1002, 3'd0, 3'd3}, N},
  '{"cont_s_1", 3'd0, S, '{16'h1003, 3'd2, 3'd3}, N},
  '{"cont_w_2", 3'd0, W, '{16'h1004, 3'd2, 3'd3}, N},
  '{"cont_e_2", 3'd0, E, '{16'h1005, 3'd1, 3'd3}, N},
  '{"cont_s_2", 3'd0, S, '{16'h1006, 3'd0, 3'd3}, N},
  '{"single_p", 3'd1, P, '{16'h2001, 3'd5, 3'd0}, W},
  '{"single_w", 3'd1, W, '{16'h2002, 3'd0, 3'd5}, E},
  '{"single_e", 3'd1, E, '{16'h2003, 3'd7, 3'd3}, S},
  '{"single_n", 3'd1, N, '{16'h2004, 3'd3, 3'd3}, P},
  '{"single_s", 3'd1, S, '{16'h2005, 3'd1, 3'd3}, N},
  '{"order_p1", 3'd2, P, '{16'h3001, 3'd5, 3'd5}, E},
  '{"order_p2", 3'd2, P, '{16'h3002, 3'd3, 3'd3}, P},
  '{"order_p3", 3'd2, P, '{16'h3003, 3'd1, 3'd1}, W},
  '{"order_p4", 3'd2, P, '{16'h3004, 3'd6, 3'd3}, S},
  '{"fill_e_1", 3'd3, E, '{16'h4001, 3'd0, 3'd0}, W},
  '{"fill_e_2", 3'd3, E, '{16'h4002, 3'd4, 3'd1}, W},
  '{"fill_e_3", 3'd3, E, '{16'h4003, 3'd3, 3'd2}, W},
  '{"fill_e_4", 3'd3, E, '{16'h4004, 3'd7, 3'd0}, W},
  '{"fill_e_5", 3'd3, E, '{16'h4005, 3'd1, 3'd1}, W},
  '{"rand_p_1", 3'd4, P, '{16'h5001, 3'd2, 3'd6}, E},
  '{"rand_w_1", 3'd4, W, '{16'h5002, 3'd5, 3'd3}, S},
  '{"rand_s_1", 3'd4, S, '{16'h5003, 3'd3, 3'd3}, P},
  '{"rand_n_1", 3'd4, N, '{16'h5004, 3'd6, 3'd3}, S},
  '{"rand_e_1", 3'd4, E, '{16'h5005, 3'd0, 3'd3}, N},
  '{"rand_w_2", 3'd4, W, '{16'h5006, 3'd4, 3'd4}, E},
  '{"rand_p_2", 3'd4, P, '{16'h5007, 3'd1, 3'd3}, N},
  '{"rand_n_2", 3'd4, N, '{16'h5008, 3'd3, 3'd3}, P}
};

// ==== tests/mesh_router_tb.sv ====
// Mesh router testbench
`timescale 1ns/1ps
`default_nettype none

module mesh_router_tb;

  import noc_pkg::*;
  import mesh_router_pkg::*;

  localparam int      timeout_lp = 200;  // Cycles allowed per wait
  localparam x_cord_t node_x_lp  = 3'd3;
  localparam y_cord_t node_y_lp  = 3'd3;

  typedef struct packed {
    dir_e        in_port;
    logic [7:0]  row;   // Table row
    logic [15:0] seq;   // Acceptance order on its input
    flit_s       flit;
  } sb_entry_s;

  `include "mesh_router_vectors.svh"

  logic                    clk_i = 1'b0;
  logic                    reset_i;
  dir_vec_t                link_v_i;
  flit_s [num_dirs_lp-1:0] link_data_i;
  dir_vec_t                link_ready_o;
  dir_vec_t                out_v_o;
  flit_s [num_dirs_lp-1:0] out_data_o;
  dir_vec_t                out_ready_i;

  sb_entry_s   sb_q [num_dirs_lp][$];    // Expected flits per output
  int          pend_q [num_dirs_lp][$];  // Rows not yet accepted on each input
  int          in_seq [num_dirs_lp];
  int          out_seq [num_dirs_lp];
  logic [31:0] lcg_state;
  int          ready_mode;               // 0 high, 1 low, 2 random
  logic        rr_check;                 // Model the N arbiter as well
  dir_e        rr_ptr;
  dir_vec_t    ready_seen;               // Sampled at the falling edge
  dir_vec_t    out_v_seen;

  mesh_router DUT (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .link_v_i     (link_v_i),
    .link_data_i  (link_data_i),
    .link_ready_o (link_ready_o),
    .out_v_o      (out_v_o),
    .out_data_o   (out_data_o),
    .out_ready_i  (out_ready_i),
    .my_x_i       (node_x_lp),
    .my_y_i       (node_y_lp)
  );

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // X first, then y, then the local port
  function automatic dir_e route_dir(input flit_s f);
    if (f.x_cord != node_x_lp) return (f.x_cord < node_x_lp) ? W : E;
    if (f.y_cord != node_y_lp) return (f.y_cord < node_y_lp) ? N : S;
    return P;
  endfunction

  task automatic fail_now(input string msg);
    $display("%0s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "Stopping at the first failed check");
  endtask

  task automatic check_delivery(input dir_e o, input flit_s got);
    int        hit;
    sb_entry_s ent;
    dir_vec_t  mask;
    dir_e      src;
    dir_e      exp_src;
    hit  = -1;
    mask = '0;
    for (int k = sb_q[o].size() - 1; k >= 0; k--) begin
      mask[sb_q[o][k].in_port] = 1'b1;  // Inputs with a flit bound here
      if (sb_q[o][k].flit == got) hit = k;
    end
    assert (hit >= 0) else
      fail_now($sformatf("Output %s delivered flit %h that was not expected", o.name(), got));
    ent = sb_q[o][hit];
    src = ent.in_port;
    sb_q[o].delete(hit);
    assert (int'(ent.seq) == out_seq[src]) else
      fail_now($sformatf("Error %0s: expected sequence %0d, actual %0d",
                         vec_tbl[ent.row].name, out_seq[src], ent.seq));
    out_seq[src]++;
    if (rr_check && o == N) begin
      exp_src = rr_ptr;
      while (!mask[exp_src]) exp_src = exp_src.next();  // Wraps from S to P
      assert (src == exp_src) else
        fail_now($sformatf("Error %0s: expected grant from %s, actual %s",
                           vec_tbl[ent.row].name, exp_src.name(), src.name()));
      rr_ptr = src.next();
    end
  endtask

  // Checks and accepts at the falling edge and drives at the rising edge
  task automatic step();
    sb_entry_s ent;
    dir_e      exp_d;
    @(negedge clk_i);
    ready_seen = link_ready_o;
    out_v_seen = out_v_o;
    for (int o = 0; o < num_dirs_lp; o++) begin
      if (out_v_o[o] && out_ready_i[o]) check_delivery(dir_e'(o), out_data_o[o]);
    end
    for (int i = 0; i < num_dirs_lp; i++) begin
      if (link_v_i[i] && link_ready_o[i]) begin
        ent.row     = 8'(pend_q[i].pop_front());
        ent.in_port = dir_e'(i);
        ent.seq     = 16'(in_seq[i]);
        ent.flit    = vec_tbl[ent.row].flit;
        exp_d       = route_dir(ent.flit);
        in_seq[i]++;
        assert (exp_d == vec_tbl[ent.row].exp_dir) else
          fail_now($sformatf("Table row %0s does not follow x-first routing",
                             vec_tbl[ent.row].name));
        sb_q[exp_d].push_back(ent);
      end
    end
    @(posedge clk_i);
    lcg_state = lcg_next(lcg_state);
    for (int i = 0; i < num_dirs_lp; i++) begin
      link_v_i[i] <= (pend_q[i].size() != 0);
      if (pend_q[i].size() != 0) link_data_i[i] <= vec_tbl[pend_q[i][0]].flit;
    end
    case (ready_mode)
      0:       out_ready_i <= '1;
      1:       out_ready_i <= '0;
      default: out_ready_i <= lcg_state[30:26];
    endcase
  endtask

  task automatic load_group(input int g);
    for (int r = 0; r < num_vecs_lp; r++) begin
      if (vec_tbl[r].grp == 3'(g)) pend_q[vec_tbl[r].in_port].push_back(r);
    end
  endtask

  function automatic int outstanding();
    int n;
    n = 0;
    for (int i = 0; i < num_dirs_lp; i++) n += pend_q[i].size() + sb_q[i].size();
    return n;
  endfunction

  task automatic drain(input int g);
    int cnt;
    cnt = 0;
    while (outstanding() != 0) begin
      assert (cnt < timeout_lp) else
        fail_now($sformatf("Timeout, flits of group %0d were never delivered", g));
      step();
      cnt++;
    end
  endtask

  // Group 3 feeds the E input while every output is stalled
  task automatic fill_and_release();
    int base;
    int cnt;
    base       = in_seq[E];
    cnt        = 0;
    ready_mode = 1;
    load_group(3);
    do begin
      assert (cnt < timeout_lp) else fail_now("Timeout, the E input never stopped accepting");
      step();
      cnt++;
    end while (ready_seen[E]);
    assert (in_seq[E] - base == fifo_depth_lp) else
      fail_now($sformatf("Error fill_e: expected %0d flits accepted, actual %0d",
                         fifo_depth_lp, in_seq[E] - base));
    ready_mode = 0;
    drain(3);
  endtask

  initial begin
    reset_i     <= 1'b0;
    link_v_i    <= '0;
    link_data_i <= '0;
    out_ready_i <= '0;
    lcg_state   = 32'd92990;
    ready_mode  = 0;
    rr_check    = 1'b0;
    rr_ptr      = P;  // Arbiter pointers start at the processor input
    for (int i = 0; i < num_dirs_lp; i++) begin
      in_seq[i]  = 0;
      out_seq[i] = 0;
    end
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b1;
    step();
    assert (ready_seen == '1 && out_v_seen == '0) else
      fail_now($sformatf("Error reset: expected ready %b valid %b, actual ready %b valid %b",
                         5'b11111, 5'b00000, ready_seen, out_v_seen));
    // Contention runs first so the N pointer is still at its reset position
    for (int g = 0; g < 5; g++) begin
      rr_check   = (g == 0);
      ready_mode = (g == 4) ? 2 : 0;
      if (g == 3) begin
        fill_and_release();
      end else begin
        load_group(g);
        drain(g);
      end
    end
    step();
    assert (out_v_seen == '0) else
      fail_now($sformatf("Error final: expected valid %b, actual %b", 5'b00000, out_v_seen));
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+tests
rtl/noc_pkg.sv
rtl/mesh_router_pkg.sv
rtl/input_fifo.sv
rtl/dor_decoder.sv
rtl/rr_arbiter.sv
rtl/output_crossbar.sv
rtl/mesh_router.sv
tests/mesh_router_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the mesh router testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sim.f --top-module mesh_router_tb -o mesh_router_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/mesh_router_sim > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "CHECKS FAILED" "$log"; then
  echo "Simulation failed"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulator exited with status $run_status"
  exit 1
fi
echo "Simulation passed"
exit 0
